/* cpuCore.f */
common/isaPkg.sv
common/corePkg.sv
regBank/regBank.sv
hdl/alu.sv
hdl/addressUnit.sv
hdl/controlUnit.sv
hdl/cpuCore.sv
tests/memoryModel.sv
tests/cpuCoreTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module cpuCoreTb -f cpuCore.f
status=0
./obj_dir/VcpuCoreTb > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ] || grep -q "TEST FAILED" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
echo "Simulation finished without failure"

/* tests/cpuCoreTb.sv */
`timescale 1ns/1ps

module cpuCoreTb
  import isaPkg::*;
  import corePkg::*;
();

  localparam int ResetCycles = 5;
  localparam int NumTests = 6;
  localparam int ProgramInstructions = 53;  // Executed instructions over all tests
  localparam int CycleLimit = ProgramInstructions * 4 + NumTests * (ResetCycles + 3) + 100;
  localparam logic [31:0] StackTop = 32'd1023;
  localparam logic [31:0] DataStart = 32'd43;
  localparam logic [31:0] SvcVector = 32'd512;
  localparam logic [3:0] zeroReg = 4'd12;  // Never written, reads 0 after reset

  logic        clock = 1'b0;
  logic        reset = 1'b1;
  logic [31:0] memRdata;
  memReq_t     memReq;
  logic        halted;
  integer      seed = 32'hfe7b_01aa;
  int          errorCount = 0;
  int          checkCount = 0;
  int          cycleCount = 0;

  cpuCore #(
    .ResetPc(32'd0), .StackTop(StackTop), .DataStart(DataStart), .SvcVector(SvcVector)
  ) i_dut (
    .clock, .reset, .memRdata, .memReq, .halted
  );

  memoryModel i_mem (.clock, .memReq, .memRdata);

  always #5 clock = ~clock;

  function automatic logic [31:0] encode(input opcode_t op, input logic [3:0] rd,
                                         input logic [3:0] ra, input logic [3:0] rb,
                                         input logic [15:0] imm);
    return {op, rd, ra, rb, imm};
  endfunction

  function automatic logic [31:0] signExtend(input logic [15:0] value);
    return {{16{value[15]}}, value};
  endfunction

  function automatic logic [15:0] randomImmediate();
    logic [31:0] word;
    word = $random(seed);
    return word[15:0];
  endfunction

  task automatic checkValue(input string what, input logic [31:0] actual,
                            input logic [31:0] expected);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("Error at %0t: %s is %h, expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic enterReset();
    @(posedge clock);
    #1 reset = 1'b1;
    i_mem.fill();
  endtask

  task automatic runToHalt();
    repeat (ResetCycles) @(posedge clock);
    #1 reset = 1'b0;
    while (!halted) begin
      @(posedge clock);
      #1;
    end
  endtask

  task automatic testResetValues();
    enterReset();
    i_mem.preload(0, encode(STORE, 4'd0, zeroReg, 4'd0, 16'd256));
    i_mem.preload(1, encode(STORE, stackReg, zeroReg, 4'd0, 16'd257));
    i_mem.preload(2, encode(HALT, 4'd0, 4'd0, 4'd0, 16'd0));
    runToHalt();
    checkValue("reset r0", i_mem.peek(256), DataStart);
    checkValue("reset sp", i_mem.peek(257), StackTop);
  endtask

  task automatic testArithmetic();
    logic [15:0] immA;
    logic [15:0] immB;
    logic [31:0] opA;
    logic [31:0] opB;
    immA = randomImmediate();
    immB = randomImmediate();
    opA = signExtend(immA);
    opB = signExtend(immB);
    enterReset();
    i_mem.preload(0, encode(ADDI, 4'd1, zeroReg, 4'd0, immA));
    i_mem.preload(1, encode(ADDI, 4'd2, zeroReg, 4'd0, immB));
    i_mem.preload(2, encode(ADD, 4'd3, 4'd1, 4'd2, 16'd0));
    i_mem.preload(3, encode(SUB, 4'd4, 4'd1, 4'd2, 16'd0));
    i_mem.preload(4, encode(AND, 4'd5, 4'd1, 4'd2, 16'd0));
    i_mem.preload(5, encode(OR, 4'd6, 4'd1, 4'd2, 16'd0));
    i_mem.preload(6, encode(XOR, 4'd7, 4'd1, 4'd2, 16'd0));
    i_mem.preload(7, encode(ADD, pcReg, 4'd1, 4'd2, 16'd0));  // Dropped, flow goes on at 8
    i_mem.preload(8, encode(STORE, 4'd3, zeroReg, 4'd0, 16'd256));
    i_mem.preload(9, encode(STORE, 4'd4, zeroReg, 4'd0, 16'd257));
    i_mem.preload(10, encode(STORE, 4'd5, zeroReg, 4'd0, 16'd258));
    i_mem.preload(11, encode(STORE, 4'd6, zeroReg, 4'd0, 16'd259));
    i_mem.preload(12, encode(STORE, 4'd7, zeroReg, 4'd0, 16'd260));
    i_mem.preload(13, encode(HALT, 4'd0, 4'd0, 4'd0, 16'd0));
    runToHalt();
    checkValue("ADD result", i_mem.peek(256), opA + opB);
    checkValue("SUB result", i_mem.peek(257), opA - opB);
    checkValue("AND result", i_mem.peek(258), opA & opB);
    checkValue("OR result", i_mem.peek(259), opA | opB);
    checkValue("XOR result", i_mem.peek(260), opA ^ opB);
  endtask

  task automatic testLoadStore();
    logic [15:0] value;
    logic [31:0] expected;
    value = randomImmediate();
    expected = signExtend(value);
    enterReset();
    i_mem.preload(0, encode(ADDI, 4'd1, zeroReg, 4'd0, value));
    i_mem.preload(1, encode(ADDI, 4'd2, zeroReg, 4'd0, 16'd300));
    i_mem.preload(2, encode(STORE, 4'd1, 4'd2, 4'd0, 16'd5));
    i_mem.preload(3, encode(LOAD, 4'd3, 4'd2, 4'd0, 16'd5));
    i_mem.preload(4, encode(STORE, 4'd3, zeroReg, 4'd0, 16'd256));
    i_mem.preload(5, encode(STORE, 4'd3, 4'd2, 4'd0, 16'hfff6));  // Offset -10
    i_mem.preload(6, encode(HALT, 4'd0, 4'd0, 4'd0, 16'd0));
    runToHalt();
    checkValue("stored word", i_mem.peek(305), expected);
    checkValue("loaded copy", i_mem.peek(256), expected);
    checkValue("negative offset", i_mem.peek(290), expected);
  endtask

  task automatic testUserStack();
    logic [15:0] values [3];
    for (int i = 0; i < 3; i++) begin
      values[i] = randomImmediate();
    end
    enterReset();
    for (int i = 0; i < 3; i++) begin
      i_mem.preload(i, encode(ADDI, 4'(i + 1), zeroReg, 4'd0, values[i]));
      i_mem.preload(3 + i, encode(PUSH, 4'(i + 1), 4'd0, 4'd0, 16'd0));
      i_mem.preload(6 + i, encode(POP, 4'(i + 4), 4'd0, 4'd0, 16'd0));
      i_mem.preload(9 + i, encode(STORE, 4'(i + 4), zeroReg, 4'd0, 16'(256 + i)));
    end
    i_mem.preload(12, encode(STORE, stackReg, zeroReg, 4'd0, 16'd259));
    i_mem.preload(13, encode(HALT, 4'd0, 4'd0, 4'd0, 16'd0));
    runToHalt();
    for (int i = 0; i < 3; i++) begin
      checkValue("pushed word", i_mem.peek(StackTop - 1 - i), signExtend(values[i]));
      checkValue("popped word", i_mem.peek(256 + i), signExtend(values[2 - i]));
    end
    checkValue("user sp after pops", i_mem.peek(259), StackTop);
  endtask

  task automatic testSupervisorCall();
    logic [15:0] marker;
    marker = randomImmediate();
    enterReset();
    i_mem.preload(0, encode(SVC, 4'd0, 4'd0, 4'd0, 16'd0));
    i_mem.preload(1, encode(ADDI, 4'd2, zeroReg, 4'd0, 16'h0c0d));  // Resume point
    i_mem.preload(2, encode(STORE, 4'd2, zeroReg, 4'd0, 16'd256));
    i_mem.preload(3, encode(STORE, stackReg, zeroReg, 4'd0, 16'd257));
    i_mem.preload(4, encode(STORE, linkReg, zeroReg, 4'd0, 16'd258));
    i_mem.preload(5, encode(HALT, 4'd0, 4'd0, 4'd0, 16'd0));
    i_mem.preload(SvcVector, encode(ADDI, 4'd3, zeroReg, 4'd0, marker));
    i_mem.preload(SvcVector + 1, encode(PUSH, 4'd3, 4'd0, 4'd0, 16'd0));
    i_mem.preload(SvcVector + 2, encode(STORE, stackReg, zeroReg, 4'd0, 16'd259));
    i_mem.preload(SvcVector + 3, encode(RET, 4'd0, 4'd0, 4'd0, 16'd0));
    runToHalt();
    checkValue("privileged push", i_mem.peek(StackTop - 1), signExtend(marker));
    checkValue("slot below push", i_mem.peek(StackTop - 2),
               i_mem.fillPattern(StackTop - 2));
    checkValue("completion value", i_mem.peek(256), 32'h0000_0c0d);
    checkValue("user sp", i_mem.peek(257), StackTop);
    checkValue("link register", i_mem.peek(258), 32'd1);  // SVC sat at address 0
    checkValue("privileged sp", i_mem.peek(259), StackTop - 1);
  endtask

  task automatic testBranch();
    enterReset();
    i_mem.preload(0, encode(BEQZ, 4'd0, zeroReg, 4'd0, 16'd2));  // Taken, lands at 3
    i_mem.preload(1, encode(STORE, 4'd0, zeroReg, 4'd0, 16'd256));
    i_mem.preload(2, encode(STORE, 4'd0, zeroReg, 4'd0, 16'd257));
    i_mem.preload(3, encode(STORE, 4'd0, zeroReg, 4'd0, 16'd258));
    i_mem.preload(4, encode(BEQZ, 4'd0, 4'd0, 4'd0, 16'd2));  // r0 nonzero, falls through
    i_mem.preload(5, encode(STORE, 4'd0, zeroReg, 4'd0, 16'd259));
    i_mem.preload(6, encode(HALT, 4'd0, 4'd0, 4'd0, 16'd0));
    i_mem.preload(7, encode(STORE, 4'd0, zeroReg, 4'd0, 16'd260));
    i_mem.preload(8, encode(HALT, 4'd0, 4'd0, 4'd0, 16'd0));
    runToHalt();
    checkValue("skipped store 1", i_mem.peek(256), i_mem.fillPattern(256));
    checkValue("skipped store 2", i_mem.peek(257), i_mem.fillPattern(257));
    checkValue("branch target", i_mem.peek(258), DataStart);
    checkValue("fall through", i_mem.peek(259), DataStart);
    checkValue("untaken target", i_mem.peek(260), i_mem.fillPattern(260));
  endtask

  initial begin
    testResetValues();
    testArithmetic();
    testLoadStore();
    testUserStack();
    testSupervisorCall();
    testBranch();
    $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    while (cycleCount < CycleLimit) begin
      @(posedge clock);
      cycleCount++;
    end
    $display("Timeout: the core did not halt within %0d cycles", CycleLimit);
    $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* tests/memoryModel.sv */
`timescale 1ns/1ps

module memoryModel
  import corePkg::*;
#(
  parameter int Depth = 1024
) (
  input  logic        clock,
  input  memReq_t     memReq,
  output logic [31:0] memRdata
);

  localparam int AddrBits = $clog2(Depth);

  logic [31:0] mem [Depth];
  logic [31:0] readData = '0;

  assign memRdata = readData;

  always @(posedge clock) begin
    if (memReq.write) begin
      mem[memReq.addr[AddrBits-1:0]] = memReq.wdata;  // Lands on the strobe edge
    end
    if (memReq.read) begin
      readData <= mem[memReq.addr[AddrBits-1:0]];  // Valid one cycle later
    end
  end

  // Unwritten words carry their address, and their opcode field decodes as HALT
  function automatic logic [31:0] fillPattern(input int unsigned addr);
    return 32'hdead_0000 ^ addr;
  endfunction

  task automatic fill();
    for (int i = 0; i < Depth; i++) begin
      mem[i] = fillPattern(i);
    end
  endtask

  task automatic preload(input int unsigned addr, input logic [31:0] word);
    mem[addr[AddrBits-1:0]] = word;
  endtask

  function automatic logic [31:0] peek(input int unsigned addr);
    return mem[addr[AddrBits-1:0]];
  endfunction

endmodule

/* hdl/cpuCore.sv */
`timescale 1ns/1ps

module cpuCore
  import isaPkg::*;
  import corePkg::*;
#(
  parameter logic [31:0] ResetPc   = 32'd0,
  parameter logic [31:0] StackTop  = 32'd1023,
  parameter logic [31:0] DataStart = 32'd43,
  parameter logic [31:0] SvcVector = 32'd512
) (
  input  logic        clock,
  input  logic        reset,
  input  logic [31:0] memRdata,
  output memReq_t     memReq,
  output logic        halted
);

  decodedInstr_t instr;
  regCtrl_t      bankCtrl;
  aluOp_t        aluOp;
  pcSel_t        pcSel;
  spSel_t        spSel;
  logic          useStack, privileged, read, write, fetch, zero;
  logic [31:0]   a, b, aluB, result, memOut, pc, sp, pcNext, spNext, memAddr;

  controlUnit i_control (
    .clock, .reset, .memRdata, .zero, .instr, .bankCtrl, .aluOp, .pcSel, .spSel,
    .useStack, .privileged, .read, .write, .halted, .fetch
  );

  regBank #(.ResetPc(ResetPc), .StackTop(StackTop), .DataStart(DataStart)) i_bank (
    .clock, .reset, .bankCtrl, .privileged, .result, .memIn(memRdata), .pcNext, .spNext,
    .a, .b, .memOut, .pc, .sp
  );

  assign aluB = (instr.opcode == ADDI) ? instr.imm : b;  // Immediate operand

  alu i_alu (.op(aluOp), .a, .b(aluB), .result, .zero);

  // Port A carries LR during RET
  addressUnit #(.SvcVector(SvcVector)) i_addr (
    .pcSel, .spSel, .useStack, .pc, .sp, .link(a), .base(a), .imm(instr.imm),
    .pcNext, .spNext, .memAddr
  );

  assign memReq = '{read: read, write: write, addr: fetch ? pc : memAddr, wdata: memOut};

endmodule

/* hdl/controlUnit.sv */
`timescale 1ns/1ps

module controlUnit
  import isaPkg::*;
  import corePkg::*;
(
  input  logic          clock,
  input  logic          reset,
  input  logic [31:0]   memRdata,
  input  logic          zero,
  output decodedInstr_t instr,
  output regCtrl_t      bankCtrl,
  output aluOp_t        aluOp,
  output pcSel_t        pcSel,
  output spSel_t        spSel,
  output logic          useStack,
  output logic          privileged,
  output logic          read,
  output logic          write,
  output logic          halted,
  output logic          fetch
);

  typedef enum logic [2:0] {sFetch, sDecode, sExecute, sWriteBack, sHalted} state_t;

  state_t state;
  logic   isMemRead;
  logic   isMemWrite;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= sFetch;
    end else begin
      case (state)
        sFetch:     state <= sDecode;
        sDecode:    state <= sExecute;
        sExecute:   state <= sWriteBack;
        sWriteBack: state <= (instr.opcode == HALT) ? sHalted : sFetch;
        default:    state <= sHalted;  // Stays until reset
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == sDecode) instr <= decode(memRdata);  // Word arrived from fetch read
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      privileged <= 1'b0;
    end else if (state == sWriteBack) begin
      if (instr.opcode == SVC) privileged <= 1'b1;
      else if (instr.opcode == RET) privileged <= 1'b0;
    end
  end

  assign isMemRead  = instr.opcode inside {LOAD, POP};
  assign isMemWrite = instr.opcode inside {STORE, PUSH};

  always_comb begin
    case (instr.opcode)
      SUB:     aluOp = aluSub;
      AND:     aluOp = aluAnd;
      OR:      aluOp = aluOr;
      XOR:     aluOp = aluXor;
      default: aluOp = aluAdd;  // ADD and ADDI
    endcase
  end

  always_comb begin
    bankCtrl.enable = (state == sWriteBack) && (instr.opcode != HALT);
    case (instr.opcode)
      ADD, SUB, AND, OR, XOR, ADDI: bankCtrl.ctrl = writeResult;
      LOAD, POP:                    bankCtrl.ctrl = writeMem;
      SVC:                          bankCtrl.ctrl = enterPriv;
      default:                      bankCtrl.ctrl = none;
    endcase
    bankCtrl.regD = instr.rd;
    bankCtrl.regA = (instr.opcode == RET) ? linkReg : instr.ra;  // LR feeds the link path
    bankCtrl.regB = instr.rb;
  end

  always_comb begin
    case (instr.opcode)
      BEQZ:    pcSel = zero ? pcBranch : pcIncrement;
      SVC:     pcSel = pcVector;
      RET:     pcSel = pcLink;
      default: pcSel = pcIncrement;
    endcase
  end

  assign spSel    = (instr.opcode == PUSH) ? spDecrement :
                    (instr.opcode == POP)  ? spIncrement : spHold;
  assign useStack = instr.opcode inside {PUSH, POP};

  assign fetch  = (state == sFetch);
  assign read   = fetch || ((state == sExecute) && isMemRead);
  assign write  = (state == sExecute) && isMemWrite;
  assign halted = (state == sHalted);

  noReadWrite: assert property (@(posedge clock) disable iff (reset) !(read && write));

  // Bank writes come three cycles after the fetch, right after execute
  enableInWriteBack: assert property (@(posedge clock) disable iff (reset)
    bankCtrl.enable |-> ($past(state) == sExecute) && ($past(state, 3) == sFetch));

endmodule

/* hdl/addressUnit.sv */
`timescale 1ns/1ps

module addressUnit
  import corePkg::*;
#(
  parameter logic [31:0] SvcVector = 32'd512
) (
  input  pcSel_t      pcSel,
  input  spSel_t      spSel,
  input  logic        useStack,
  input  logic [31:0] pc,
  input  logic [31:0] sp,
  input  logic [31:0] link,
  input  logic [31:0] base,
  input  logic [31:0] imm,
  output logic [31:0] pcNext,
  output logic [31:0] spNext,
  output logic [31:0] memAddr
);

  logic [31:0] pcPlusOne;

  assign pcPlusOne = pc + 32'd1;

  always_comb begin
    case (pcSel)
      pcIncrement: pcNext = pcPlusOne;
      pcBranch:    pcNext = pcPlusOne + imm;  // Relative to the next instruction
      pcVector:    pcNext = SvcVector;
      pcLink:      pcNext = link;
      default:     pcNext = pcPlusOne;
    endcase
  end

  always_comb begin
    case (spSel)
      spDecrement: spNext = sp - 32'd1;
      spIncrement: spNext = sp + 32'd1;
      default:     spNext = sp;
    endcase
  end

  // Push is pre-decrement, pop reads the current top
  always_comb begin
    if (useStack) begin
      memAddr = (spSel == spDecrement) ? sp - 32'd1 : sp;
    end else begin
      memAddr = base + imm;
    end
  end

endmodule

/* hdl/alu.sv */
`timescale 1ns/1ps

module alu
  import isaPkg::*;
(
  input  aluOp_t      op,
  input  logic [31:0] a,
  input  logic [31:0] b,
  output logic [31:0] result,
  output logic        zero
);

  always_comb begin
    case (op)
      aluAdd:   result = a + b;
      aluSub:   result = a - b;
      aluAnd:   result = a & b;
      aluOr:    result = a | b;
      aluXor:   result = a ^ b;
      aluPassB: result = b;
      default:  result = '0;
    endcase
  end

  // Tests operand A so BEQZ needs no subtraction
  assign zero = (a == '0);

endmodule

/* regBank/regBank.sv */
`timescale 1ns/1ps

module regBank
  import corePkg::*;
#(
  parameter logic [31:0] ResetPc   = 32'd0,
  parameter logic [31:0] StackTop  = 32'd1023,
  parameter logic [31:0] DataStart = 32'd43
) (
  input  logic        clock,
  input  logic        reset,
  input  regCtrl_t    bankCtrl,
  input  logic        privileged,
  input  logic [31:0] result,
  input  logic [31:0] memIn,
  input  logic [31:0] pcNext,
  input  logic [31:0] spNext,
  output logic [31:0] a,
  output logic [31:0] b,
  output logic [31:0] memOut,
  output logic [31:0] pc,
  output logic [31:0] sp
);

  logic [31:0] regs [14];   // r0 to r13, r14 and r15 live apart
  logic [31:0] progCounter;
  logic [31:0] userSp;
  logic [31:0] privSp;

  assign sp = privileged ? privSp : userSp;  // Active stack pointer
  assign pc = progCounter;

  function automatic logic [31:0] readReg(input logic [3:0] idx);
    if (idx == stackReg) return sp;
    if (idx == pcReg) return progCounter;
    return regs[idx];
  endfunction

  assign a      = readReg(bankCtrl.regA);
  assign b      = readReg(bankCtrl.regB);
  assign memOut = readReg(bankCtrl.regD);  // Store and push data

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < 14; i++) begin
        regs[i] <= '0;
      end
      regs[0]     <= DataStart;
      progCounter <= ResetPc;
      userSp      <= StackTop;
      privSp      <= StackTop;
    end else if (bankCtrl.enable) begin
      progCounter <= pcNext;
      if (privileged) begin
        privSp <= (bankCtrl.ctrl == resetStack) ? StackTop : spNext;
      end else begin
        userSp <= (bankCtrl.ctrl == resetStack) ? StackTop : spNext;
      end
      case (bankCtrl.ctrl)
        writeResult: begin
          if (bankCtrl.regD < stackReg) regs[bankCtrl.regD] <= result;  // r14/r15 ignored
        end
        resetStack: regs[0] <= DataStart;
        writeMem: begin
          if (bankCtrl.regD < stackReg) regs[bankCtrl.regD] <= memIn;
        end
        enterPriv: regs[linkReg] <= progCounter + 32'd1;  // Return lands after SVC
        default: ;
      endcase
    end
  end

  ctrlCodeValid: assert property (@(posedge clock) disable iff (reset)
    bankCtrl.enable |-> bankCtrl.ctrl inside {none, writeResult, resetStack, writeMem, enterPriv});

endmodule

/* common/corePkg.sv */
package corePkg;

  // Register bank write actions
  typedef enum logic [2:0] {
    none        = 3'd0,
    writeResult = 3'd1,  // rd from the ALU
    resetStack  = 3'd2,
    writeMem    = 3'd3,  // rd from the memory bus
    enterPriv   = 3'd4
  } bankCtrl_t;

  typedef struct packed {
    logic       enable;
    bankCtrl_t  ctrl;
    logic [3:0] regD;
    logic [3:0] regA;
    logic [3:0] regB;
  } regCtrl_t;

  // Special register indices
  localparam logic [3:0] linkReg  = 4'd13;
  localparam logic [3:0] stackReg = 4'd14;
  localparam logic [3:0] pcReg    = 4'd15;

  typedef enum logic [1:0] {
    pcIncrement = 2'd0,
    pcBranch    = 2'd1,
    pcVector    = 2'd2,
    pcLink      = 2'd3
  } pcSel_t;

  typedef enum logic [1:0] {
    spHold      = 2'd0,
    spDecrement = 2'd1,
    spIncrement = 2'd2
  } spSel_t;

  typedef struct packed {
    logic        read;
    logic        write;
    logic [31:0] addr;   // Word address
    logic [31:0] wdata;
  } memReq_t;

endpackage

/* common/isaPkg.sv */
package isaPkg;

  // Instruction opcodes, bits 31 to 28 of every instruction word
  typedef enum logic [3:0] {
    ADD   = 4'd0,
    SUB   = 4'd1,
    AND   = 4'd2,
    OR    = 4'd3,
    XOR   = 4'd4,
    ADDI  = 4'd5,
    LOAD  = 4'd6,
    STORE = 4'd7,
    PUSH  = 4'd8,
    POP   = 4'd9,
    BEQZ  = 4'd10,
    SVC   = 4'd11,
    RET   = 4'd12,
    HALT  = 4'd13
  } opcode_t;

  // Field positions inside the instruction word
  localparam int OpcodeLsb = 28;
  localparam int RdLsb     = 24;
  localparam int RaLsb     = 20;
  localparam int RbLsb     = 16;
  localparam int ImmWidth  = 16;

  typedef struct packed {
    opcode_t     opcode;
    logic [3:0]  rd;
    logic [3:0]  ra;
    logic [3:0]  rb;
    logic [31:0] imm;  // Already sign extended
  } decodedInstr_t;

  typedef enum logic [2:0] {
    aluAdd   = 3'd0,
    aluSub   = 3'd1,
    aluAnd   = 3'd2,
    aluOr    = 3'd3,
    aluXor   = 3'd4,
    aluPassB = 3'd5
  } aluOp_t;

  // Splits a fetched word into its fields
  function automatic decodedInstr_t decode(input logic [31:0] word);
    decodedInstr_t d;
    d.opcode = opcode_t'(word[OpcodeLsb +: 4]);
    d.rd     = word[RdLsb +: 4];
    d.ra     = word[RaLsb +: 4];
    d.rb     = word[RbLsb +: 4];
    d.imm    = {{(32 - ImmWidth){word[ImmWidth-1]}}, word[ImmWidth-1:0]};
    return d;
  endfunction

endpackage
